// ==== sim/decodeStimulus.txt ====
// instr    wbData opcode dest src1 src2 imm  taken
// dest/src values and taken flag follow the decode rules, R0..R15 start at zero
31000000 0000 31 0 0000 0000 0000 1
30000000 0000 30 0 0000 0000 0000 0
32000000 0000 32 0 0000 0000 0000 0
2101FFF0 FFF0 21 1 0000 0000 FFF0 0
30000000 0000 30 0 0000 0000 0000 1
1121FFFD FFED 11 2 FFF0 0000 FFFD 0
10320100 FFDD 10 3 FFED FFF0 0100 0
15438F0F 8F0D 15 4 FFDD 0000 8F0F 0
21050000 0000 21 5 0000 0000 0000 0
31000000 0000 31 0 0000 0000 0000 1
34000000 0000 34 0 0000 0000 0000 0
21060042 0042 21 6 0000 0000 0042 0
32000000 0000 32 0 0000 0000 0000 1
33000000 0000 33 0 0000 0000 0000 0
35000000 0000 35 0 0000 0000 0000 1
36000000 0000 36 0 0000 0000 0000 1
20070600 0042 20 7 0000 0042 0600 0
20080900 0000 20 8 0000 0000 0900 0
14A30700 0040 14 A FFDD 0042 0700 0
EE123456 0000 00 0 0000 0000 3456 0
11BA0001 0041 11 B 0040 0000 0001 0
10CB0B00 0082 10 C 0041 0041 0B00 0
00000000 0000 00 0 0000 0000 0000 0
30000000 0000 30 0 0000 0000 0000 0
15D1FF00 FF00 15 D FFF0 0000 FF00 0
33000000 0000 33 0 0000 0000 0000 1
11E0FFFF FFFF 11 E 0000 0000 FFFF 0
10FE0D00 FEFF 10 F FFFF FF00 0D00 0
35000000 0000 35 0 0000 0000 0000 0

// ==== project.f ====
verilog/decodePkg.sv
verilog/instrDecoder.sv
verilog/regScoreboard.sv
verilog/issueStage.sv
verilog/decodeStage.sv
sim/tbDecodeStage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - files:
      - verilog/decodePkg.sv
      - verilog/instrDecoder.sv
      - verilog/regScoreboard.sv
      - verilog/issueStage.sv
      - verilog/decodeStage.sv
  - target: simulation
    files:
      - sim/tbDecodeStage.sv

// ==== sim/tbDecodeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbDecodeStage import decodePkg::*; ();

  localparam int dataWidth   = 16;
  localparam int regCount    = 16;
  localparam int idxWidth    = $clog2(regCount);
  localparam int lineCount   = 29;   // Instructions in the stimulus file
  localparam int colCount    = 8;    // Words per stimulus line
  localparam int clockPeriod = 100;
  localparam int driveDelay  = 10;   // Inputs move this long after the rising edge
  localparam int resetCycles = 16;
  localparam int drainCycles = 20;   // Quiet window after the last instruction
  localparam int cycleLimit  = lineCount * 40 + resetCycles + drainCycles;

  logic                 I_CLOCK;
  logic                 arstN;
  logic                 fetchReq;
  logic [INSTR_WIDTH-1:0] fetchInstr;
  logic                 fetchAck;
  logic                 wbEnable;
  logic [idxWidth-1:0]  wbRegIdx;
  logic [dataWidth-1:0] wbData;
  logic                 execAck;
  logic                 execReq;
  opcodeT               execOpcode;
  logic [idxWidth-1:0]  execDestIdx;
  logic [dataWidth-1:0] execSrc1Value;
  logic [dataWidth-1:0] execSrc2Value;
  logic [dataWidth-1:0] execImm;
  logic                 execBranchTaken;

  // Eight words per line in file column order
  logic [31:0] stimMem [lineCount * colCount];
  integer      seed       = 32'h1ecb1058;
  int          cycleCount = 0;

  decodeStage #(.dataWidth(dataWidth), .regCount(regCount)) i_decodeStage (
    .I_CLOCK(I_CLOCK), .arstN(arstN),
    .fetchReq(fetchReq), .fetchInstr(fetchInstr), .fetchAck(fetchAck),
    .wbEnable(wbEnable), .wbRegIdx(wbRegIdx), .wbData(wbData),
    .execAck(execAck), .execReq(execReq), .execOpcode(execOpcode),
    .execDestIdx(execDestIdx), .execSrc1Value(execSrc1Value),
    .execSrc2Value(execSrc2Value), .execImm(execImm),
    .execBranchTaken(execBranchTaken)
  );

  //////////////////////////////////////////////////
  // Clock and timeout
  //////////////////////////////////////////////////
  initial begin
    I_CLOCK = 1'b0;
    forever #(clockPeriod / 2) I_CLOCK = ~I_CLOCK;
  end

  always @(posedge I_CLOCK) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
      $display("Verification failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  // One edge plus the drive delay where outputs are stable
  task automatic stepCycle();
    @(posedge I_CLOCK);
    #driveDelay;
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %0t %s: got %h, expected %h", $time, name, actual, expected);
      $display("Verification failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Opcodes that write a register and so get a writeback
  function automatic bit writesReg(input logic [7:0] op);
    case (op)
      opAdd, opAnd, opAddi, opAndi, opMov, opMovi: writesReg = 1'b1;
      default:                                     writesReg = 1'b0;
    endcase
  endfunction

  task automatic checkOutputs(input int line);
    int base;
    base = line * colCount;
    checkValue("execOpcode",      execOpcode,      stimMem[base + 2]);
    checkValue("execDestIdx",     execDestIdx,     stimMem[base + 3]);
    checkValue("execSrc1Value",   execSrc1Value,   stimMem[base + 4]);
    checkValue("execSrc2Value",   execSrc2Value,   stimMem[base + 5]);
    checkValue("execImm",         execImm,         stimMem[base + 6]);
    checkValue("execBranchTaken", execBranchTaken, stimMem[base + 7]);
  endtask

  //////////////////////////////////////////////////
  // Four-phase fetch in file order
  //////////////////////////////////////////////////
  task automatic driveFetch();
    for (int line = 0; line < lineCount; line++) begin
      fetchInstr = stimMem[line * colCount];
      fetchReq   = 1'b1;
      do stepCycle(); while (!fetchAck);  // Word captured on this edge
      fetchReq = 1'b0;
      do stepCycle(); while (fetchAck);
    end
  endtask

  //////////////////////////////////////////////////
  // Execute side and writeback
  //////////////////////////////////////////////////
  // One instruction at a time so writebacks land in program order
  task automatic runExecute();
    int base;
    int delay;
    for (int line = 0; line < lineCount; line++) begin
      base = line * colCount;
      do stepCycle(); while (!execReq);
      checkOutputs(line);
      delay = $unsigned($random(seed)) % 5;  // Back-pressure 0..4 cycles
      repeat (delay) stepCycle();
      checkOutputs(line);                    // Still held under back-pressure
      execAck = 1'b1;
      do stepCycle(); while (execReq);
      execAck = 1'b0;
      if (writesReg(stimMem[base + 2][7:0])) begin
        delay = $unsigned($random(seed)) % 7;  // Late result 0..6 cycles
        repeat (delay) stepCycle();
        wbEnable = 1'b1;
        wbRegIdx = stimMem[base + 3][idxWidth-1:0];
        wbData   = stimMem[base + 1][dataWidth-1:0];
        stepCycle();
        wbEnable = 1'b0;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    arstN      = 1'b0;
    fetchReq   = 1'b0;
    fetchInstr = '0;
    wbEnable   = 1'b0;
    wbRegIdx   = '0;
    wbData     = '0;
    execAck    = 1'b0;
    $readmemh("sim/decodeStimulus.txt", stimMem);
    repeat (resetCycles) @(posedge I_CLOCK);
    #driveDelay;
    arstN = 1'b1;
    fork
      driveFetch();
      runExecute();
    join
    // No extra issue may follow the last line
    repeat (drainCycles) begin
      stepCycle();
      checkValue("execReq", execReq, '0);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/decodeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeStage import decodePkg::*; #(
  parameter  int dataWidth = 16,
  parameter  int regCount  = 16,
  localparam int idxWidth  = $clog2(regCount)
) (
  input  wire                    I_CLOCK,
  input  wire                    arstN,
  // Fetch
  input  wire                    fetchReq,
  input  wire  [INSTR_WIDTH-1:0] fetchInstr,
  output logic                   fetchAck,
  // Writeback
  input  wire                    wbEnable,
  input  wire  [idxWidth-1:0]    wbRegIdx,
  input  wire  [dataWidth-1:0]   wbData,
  // Execute
  input  wire                    execAck,
  output logic                   execReq,
  output opcodeT                 execOpcode,
  output logic [idxWidth-1:0]    execDestIdx,
  output logic [dataWidth-1:0]   execSrc1Value,
  output logic [dataWidth-1:0]   execSrc2Value,
  output logic [dataWidth-1:0]   execImm,
  output logic                   execBranchTaken
);

  //////////////////////////////////////////////////
  // Decoder slot to issue
  //////////////////////////////////////////////////
  logic                       decValid;
  logic                       decTake;
  opcodeT                     decOpcode;
  logic [REG_FIELD_WIDTH-1:0] decDestIdx;
  logic [REG_FIELD_WIDTH-1:0] decSrc1Idx;
  logic [REG_FIELD_WIDTH-1:0] decSrc2Idx;
  logic [dataWidth-1:0]       decImm;
  logic                       decNeedSrc1;
  logic                       decNeedSrc2;
  logic                       decWritesDest;
  logic [2:0]                 decBranchMask;

  // Issue to scoreboard
  logic [idxWidth-1:0]  src1Idx;
  logic [idxWidth-1:0]  src2Idx;
  logic [dataWidth-1:0] src1Value;
  logic                 src1Ready;
  logic [dataWidth-1:0] src2Value;
  logic                 src2Ready;
  logic                 setBusy;
  logic [idxWidth-1:0]  busyIdx;
  logic                 anyBusy;
  condCodeT             condCode;

  instrDecoder #(.dataWidth(dataWidth)) i_instrDecoder (
    .I_CLOCK(I_CLOCK), .arstN(arstN),
    .fetchReq(fetchReq), .fetchInstr(fetchInstr), .fetchAck(fetchAck),
    .decTake(decTake), .decValid(decValid), .decOpcode(decOpcode),
    .decDestIdx(decDestIdx), .decSrc1Idx(decSrc1Idx), .decSrc2Idx(decSrc2Idx),
    .decImm(decImm), .decNeedSrc1(decNeedSrc1), .decNeedSrc2(decNeedSrc2),
    .decWritesDest(decWritesDest), .decBranchMask(decBranchMask)
  );

  regScoreboard #(.dataWidth(dataWidth), .regCount(regCount)) i_regScoreboard (
    .I_CLOCK(I_CLOCK), .arstN(arstN),
    .wbEnable(wbEnable), .wbRegIdx(wbRegIdx), .wbData(wbData),
    .src1Idx(src1Idx), .src2Idx(src2Idx),
    .src1Value(src1Value), .src1Ready(src1Ready),
    .src2Value(src2Value), .src2Ready(src2Ready),
    .setBusy(setBusy), .busyIdx(busyIdx), .anyBusy(anyBusy), .condCode(condCode)
  );

  issueStage #(.dataWidth(dataWidth), .regCount(regCount)) i_issueStage (
    .I_CLOCK(I_CLOCK), .arstN(arstN),
    .decValid(decValid), .decOpcode(decOpcode), .decDestIdx(decDestIdx),
    .decSrc1Idx(decSrc1Idx), .decSrc2Idx(decSrc2Idx), .decImm(decImm),
    .decNeedSrc1(decNeedSrc1), .decNeedSrc2(decNeedSrc2),
    .decWritesDest(decWritesDest), .decBranchMask(decBranchMask), .decTake(decTake),
    .src1Idx(src1Idx), .src2Idx(src2Idx),
    .src1Value(src1Value), .src1Ready(src1Ready),
    .src2Value(src2Value), .src2Ready(src2Ready),
    .anyBusy(anyBusy), .condCode(condCode), .setBusy(setBusy), .busyIdx(busyIdx),
    .execAck(execAck), .execReq(execReq), .execOpcode(execOpcode),
    .execDestIdx(execDestIdx), .execSrc1Value(execSrc1Value),
    .execSrc2Value(execSrc2Value), .execImm(execImm),
    .execBranchTaken(execBranchTaken)
  );

endmodule

`default_nettype wire

// ==== verilog/issueStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module issueStage import decodePkg::*; #(
  parameter  int dataWidth = 16,
  parameter  int regCount  = 16,
  localparam int idxWidth  = $clog2(regCount)
) (
  input  wire                        I_CLOCK,
  input  wire                        arstN,
  // From the decoder slot
  input  wire                        decValid,
  input  wire  opcodeT               decOpcode,
  input  wire  [REG_FIELD_WIDTH-1:0] decDestIdx,
  input  wire  [REG_FIELD_WIDTH-1:0] decSrc1Idx,
  input  wire  [REG_FIELD_WIDTH-1:0] decSrc2Idx,
  input  wire  [dataWidth-1:0]       decImm,
  input  wire                        decNeedSrc1,
  input  wire                        decNeedSrc2,
  input  wire                        decWritesDest,
  input  wire  [2:0]                 decBranchMask,
  output logic                       decTake,
  // Scoreboard
  output logic [idxWidth-1:0]        src1Idx,
  output logic [idxWidth-1:0]        src2Idx,
  input  wire  [dataWidth-1:0]       src1Value,
  input  wire                        src1Ready,
  input  wire  [dataWidth-1:0]       src2Value,
  input  wire                        src2Ready,
  input  wire                        anyBusy,
  input  wire  condCodeT             condCode,
  output logic                       setBusy,
  output logic [idxWidth-1:0]        busyIdx,
  // Execute side, four-phase
  input  wire                        execAck,
  output logic                       execReq,
  output opcodeT                     execOpcode,
  output logic [idxWidth-1:0]        execDestIdx,
  output logic [dataWidth-1:0]       execSrc1Value,
  output logic [dataWidth-1:0]       execSrc2Value,
  output logic [dataWidth-1:0]       execImm,
  output logic                       execBranchTaken
);

  typedef enum logic [1:0] {idle, reqHigh, waitAckLow} issueStateT;

  issueStateT issueState;
  logic       isBranch;
  logic       operandsReady;

  //////////////////////////////////////////////////
  // Readiness
  //////////////////////////////////////////////////
  assign src1Idx  = decSrc1Idx[idxWidth-1:0];
  assign src2Idx  = decSrc2Idx[idxWidth-1:0];
  assign isBranch = |decBranchMask;

  // Branches wait for every writeback to drain, the rest only for their sources
  assign operandsReady = isBranch ? !anyBusy
                                  : ((!decNeedSrc1 || src1Ready) &&
                                     (!decNeedSrc2 || src2Ready));

  assign decTake = (issueState == idle) && decValid && operandsReady;  // Accept pulse
  assign setBusy = decTake && decWritesDest;
  assign busyIdx = decDestIdx[idxWidth-1:0];
  assign execReq = (issueState == reqHigh);

  //////////////////////////////////////////////////
  // Execute handshake
  //////////////////////////////////////////////////
  always_ff @(posedge I_CLOCK or negedge arstN) begin
    if (!arstN) begin
      issueState <= idle;
    end else begin
      case (issueState)
        idle:       if (decTake) issueState <= reqHigh;     // Req one edge after ready
        reqHigh:    if (execAck) issueState <= waitAckLow;  // Drop req
        waitAckLow: if (!execAck) issueState <= idle;       // Handshake closed
        default:    issueState <= idle;
      endcase
    end
  end

  // Operands latched on accept, frozen until the next accept
  always_ff @(posedge I_CLOCK) begin
    if (decTake) begin
      execOpcode      <= decOpcode;
      execDestIdx     <= decDestIdx[idxWidth-1:0];
      execSrc1Value   <= decNeedSrc1 ? src1Value : '0;  // Unused sources read as zero
      execSrc2Value   <= decNeedSrc2 ? src2Value : '0;
      execImm         <= decImm;
      execBranchTaken <= |(decBranchMask & condCode);  // Zero mask for non-branches
    end
  end

  // Execute sees a steady word until it acknowledges
  execHeldStable: assert property (@(posedge I_CLOCK) disable iff (!arstN)
    (execReq && !execAck) |=> (execReq &&
      $stable({execOpcode, execDestIdx, execSrc1Value, execSrc2Value,
               execImm, execBranchTaken})))
    else $error("Execute outputs changed before execAck");

endmodule

`default_nettype wire

// ==== verilog/regScoreboard.sv ====
`timescale 1ns/10ps
`default_nettype none

module regScoreboard import decodePkg::*; #(
  parameter  int dataWidth = 16,
  parameter  int regCount  = 16,
  localparam int idxWidth  = $clog2(regCount)
) (
  input  wire                  I_CLOCK,
  input  wire                  arstN,
  // Writeback strobe from execute
  input  wire                  wbEnable,
  input  wire  [idxWidth-1:0]  wbRegIdx,
  input  wire  [dataWidth-1:0] wbData,
  // Read ports
  input  wire  [idxWidth-1:0]  src1Idx,
  input  wire  [idxWidth-1:0]  src2Idx,
  output logic [dataWidth-1:0] src1Value,
  output logic                 src1Ready,
  output logic [dataWidth-1:0] src2Value,
  output logic                 src2Ready,
  // Issue marks its destination pending
  input  wire                  setBusy,
  input  wire  [idxWidth-1:0]  busyIdx,
  output logic                 anyBusy,
  output condCodeT             condCode
);

  logic [dataWidth-1:0] regFile [regCount];
  logic [regCount-1:0]  busyBits;  // 1 = waiting for writeback
  logic                 src1Hit;
  logic                 src2Hit;

  //////////////////////////////////////////////////
  // Register file and condition code
  //////////////////////////////////////////////////
  always_ff @(posedge I_CLOCK or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < regCount; i++) begin
        regFile[i] <= '0;  // Registers read zero until written
      end
    end else if (wbEnable) begin
      regFile[wbRegIdx] <= wbData;
    end
  end

  always_ff @(posedge I_CLOCK or negedge arstN) begin
    if (!arstN) begin
      condCode <= ccZero;
    end else if (wbEnable) begin
      if (wbData[dataWidth-1]) begin
        condCode <= ccNeg;   // Top bit set
      end else if (|wbData) begin
        condCode <= ccPos;
      end else begin
        condCode <= ccZero;
      end
    end
  end

  //////////////////////////////////////////////////
  // Busy bits
  //////////////////////////////////////////////////
  always_ff @(posedge I_CLOCK or negedge arstN) begin
    if (!arstN) begin
      busyBits <= '0;
    end else begin
      if (wbEnable) begin
        busyBits[wbRegIdx] <= 1'b0;
      end
      // Set after clear, a same-edge reissue to that register stays pending
      if (setBusy) begin
        busyBits[busyIdx] <= 1'b1;
      end
    end
  end

  // Registered view only, so a branch sees the updated condition code
  assign anyBusy = |busyBits;

  //////////////////////////////////////////////////
  // Read ports with writeback bypass
  //////////////////////////////////////////////////
  assign src1Hit   = wbEnable && (wbRegIdx == src1Idx);
  assign src2Hit   = wbEnable && (wbRegIdx == src2Idx);
  assign src1Value = src1Hit ? wbData : regFile[src1Idx];
  assign src2Value = src2Hit ? wbData : regFile[src2Idx];
  assign src1Ready = src1Hit || !busyBits[src1Idx];
  assign src2Ready = src2Hit || !busyBits[src2Idx];

  // Execute only writes back what issue marked pending
  wbTargetsBusy: assert property (@(posedge I_CLOCK) disable iff (!arstN)
    wbEnable |-> busyBits[wbRegIdx])
    else $error("Writeback to idle register %0d", wbRegIdx);

  // Destination hazards are not tracked, a pending register must not be reissued
  setBusyOnIdle: assert property (@(posedge I_CLOCK) disable iff (!arstN)
    setBusy |-> (!busyBits[busyIdx] || (wbEnable && (wbRegIdx == busyIdx))))
    else $error("setBusy on pending register %0d", busyIdx);

endmodule

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instrDecoder import decodePkg::*; #(
  parameter int dataWidth = 16
) (
  input  wire                        I_CLOCK,
  input  wire                        arstN,
  // Fetch side, four-phase
  input  wire                        fetchReq,
  input  wire  [INSTR_WIDTH-1:0]     fetchInstr,
  output logic                       fetchAck,
  // Holding slot towards issue
  input  wire                        decTake,     // One-cycle accept pulse
  output logic                       decValid,
  output opcodeT                     decOpcode,
  output logic [REG_FIELD_WIDTH-1:0] decDestIdx,
  output logic [REG_FIELD_WIDTH-1:0] decSrc1Idx,
  output logic [REG_FIELD_WIDTH-1:0] decSrc2Idx,
  output logic [dataWidth-1:0]       decImm,
  output logic                       decNeedSrc1,
  output logic                       decNeedSrc2,
  output logic                       decWritesDest,
  output logic [2:0]                 decBranchMask  // N/Z/P
);

  typedef enum logic [1:0] {idle, acked, waitLow} fetchStateT;

  fetchStateT                 fetchState;
  logic                       slotFree;
  logic                       capture;
  logic [7:0]                 rawOpcode;
  logic [IMM_WIDTH-1:0]       immField;
  opcodeT                     nextOpcode;
  logic [REG_FIELD_WIDTH-1:0] nextDestIdx;
  logic                       nextNeedSrc1;
  logic                       nextNeedSrc2;
  logic                       nextWritesDest;
  logic [2:0]                 nextBranchMask;

  //////////////////////////////////////////////////
  // Fetch handshake
  //////////////////////////////////////////////////
  assign slotFree = !decValid;
  assign capture  = fetchReq && slotFree && (fetchState != acked);  // Word latched here
  assign fetchAck = (fetchState == acked);

  // waitLow: request pending, slot still full
  always_ff @(posedge I_CLOCK or negedge arstN) begin
    if (!arstN) begin
      fetchState <= idle;
    end else begin
      case (fetchState)
        idle:    if (fetchReq) fetchState <= slotFree ? acked : waitLow;
        waitLow: if (slotFree) fetchState <= acked;
        acked:   if (!fetchReq) fetchState <= idle;  // Ack drops after req drops
        default: fetchState <= idle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Field decode
  //////////////////////////////////////////////////
  assign rawOpcode = fetchInstr[OPCODE_MSB:OPCODE_LSB];
  assign immField  = fetchInstr[IMM_WIDTH-1:0];

  always_comb begin
    nextOpcode     = opNop;  // Unknown opcodes fall through as NOP
    nextDestIdx    = '0;
    nextNeedSrc1   = 1'b0;
    nextNeedSrc2   = 1'b0;
    nextWritesDest = 1'b0;
    nextBranchMask = 3'b000;
    case (rawOpcode)
      opAdd, opAnd: begin
        nextOpcode     = opcodeT'(rawOpcode);
        nextDestIdx    = fetchInstr[DEST_LSB +: REG_FIELD_WIDTH];
        nextNeedSrc1   = 1'b1;
        nextNeedSrc2   = 1'b1;
        nextWritesDest = 1'b1;
      end
      opAddi, opAndi: begin
        nextOpcode     = opcodeT'(rawOpcode);
        nextDestIdx    = fetchInstr[DEST_LSB +: REG_FIELD_WIDTH];
        nextNeedSrc1   = 1'b1;
        nextWritesDest = 1'b1;
      end
      opMov: begin
        nextOpcode     = opMov;
        nextDestIdx    = fetchInstr[SRC1_LSB +: REG_FIELD_WIDTH];  // Dest from src1 field
        nextNeedSrc2   = 1'b1;                                     // Source from src2 field
        nextWritesDest = 1'b1;
      end
      opMovi: begin
        nextOpcode     = opMovi;
        nextDestIdx    = fetchInstr[SRC1_LSB +: REG_FIELD_WIDTH];
        nextWritesDest = 1'b1;
      end
      opBrn:   begin nextOpcode = opBrn;   nextBranchMask = 3'b100; end
      opBrz:   begin nextOpcode = opBrz;   nextBranchMask = 3'b010; end
      opBrp:   begin nextOpcode = opBrp;   nextBranchMask = 3'b001; end
      opBrnz:  begin nextOpcode = opBrnz;  nextBranchMask = 3'b110; end
      opBrnp:  begin nextOpcode = opBrnp;  nextBranchMask = 3'b101; end
      opBrzp:  begin nextOpcode = opBrzp;  nextBranchMask = 3'b011; end
      opBrnzp: begin nextOpcode = opBrnzp; nextBranchMask = 3'b111; end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // Holding slot
  //////////////////////////////////////////////////
  always_ff @(posedge I_CLOCK or negedge arstN) begin
    if (!arstN) begin
      decValid <= 1'b0;
    end else if (capture) begin
      decValid <= 1'b1;
    end else if (decTake) begin
      decValid <= 1'b0;  // Freed on the accept edge
    end
  end

  // Payload only, qualified by decValid
  always_ff @(posedge I_CLOCK) begin
    if (capture) begin
      decOpcode     <= nextOpcode;
      decDestIdx    <= nextDestIdx;
      decSrc1Idx    <= fetchInstr[SRC1_LSB +: REG_FIELD_WIDTH];
      decSrc2Idx    <= fetchInstr[SRC2_LSB +: REG_FIELD_WIDTH];
      decImm        <= dataWidth'($signed(immField));  // Sign extend from bit 15
      decNeedSrc1   <= nextNeedSrc1;
      decNeedSrc2   <= nextNeedSrc2;
      decWritesDest <= nextWritesDest;
      decBranchMask <= nextBranchMask;
    end
  end

  // Ack may only answer a request seen on the previous edge
  ackFollowsReq: assert property (@(posedge I_CLOCK) disable iff (!arstN)
    $rose(fetchAck) |-> $past(fetchReq))
    else $error("fetchAck rose without fetchReq");

endmodule

`default_nettype wire

// ==== verilog/decodePkg.sv ====
`default_nettype none

package decodePkg;

  //////////////////////////////////////////////////
  // Instruction word layout
  //////////////////////////////////////////////////
  localparam int INSTR_WIDTH     = 32;
  localparam int OPCODE_MSB      = 31;
  localparam int OPCODE_LSB      = 24;
  localparam int DEST_LSB        = 20;  // Dest of ADD/AND/ADDI/ANDI
  localparam int SRC1_LSB        = 16;  // Also dest of MOV and MOVI
  localparam int SRC2_LSB        = 8;   // Also source of MOV
  localparam int IMM_WIDTH       = 16;  // Immediate sits in bits 15..0
  localparam int REG_FIELD_WIDTH = 4;   // Every register field

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////
  // Anything not listed decodes as opNop
  typedef enum logic [7:0] {
    opNop   = 8'h00,
    opAdd   = 8'h10,
    opAddi  = 8'h11,
    opAnd   = 8'h14,
    opAndi  = 8'h15,
    opMov   = 8'h20,
    opMovi  = 8'h21,
    opBrn   = 8'h30,  // Mask 100
    opBrz   = 8'h31,  // Mask 010
    opBrp   = 8'h32,  // Mask 001
    opBrnz  = 8'h33,
    opBrnp  = 8'h34,
    opBrzp  = 8'h35,
    opBrnzp = 8'h36   // Always taken
  } opcodeT;

  //////////////////////////////////////////////////
  // Condition code
  //////////////////////////////////////////////////
  // One-hot, same bit order as the branch N/Z/P mask
  typedef enum logic [2:0] {
    ccPos  = 3'b001,
    ccZero = 3'b010,
    ccNeg  = 3'b100
  } condCodeT;

endpackage

`default_nettype wire
